//--- src.f
+incdir+common
common/rv32i_pkg.sv
common/tomasulo_pkg.sv
common/dispatch_if.sv
front/fetch_decode.sv
front/instr_queue.sv
verilog/front_end_top.sv
sim/front_end_sva.sv
sim/front_end_tb.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module front_end_tb -Mdir obj_dir \
    && { ./obj_dir/Vfront_end_tb > sim.log 2>&1 || true; } \
    && grep -qx "STATUS: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- sim/front_end_tb.sv
`timescale 1ns/1ns
`include "front_consts.svh"

module front_end_tb;
    import rv32i_pkg::*;
    import tomasulo_pkg::*;

    localparam logic [31:0] JALR_TGT = 32'h200;
    localparam logic [31:0] FLUSH_PC = 32'h400;

    logic clk, rst;
    logic instr_read, instr_mem_resp, br_pr_take, ld_br_pc, flush_ip, deq, out_valid;
    logic [31:0] instr_mem_address, instr_rdata, br_pc;
    logic [`JALR_PORTS-1:0]       jalr_done;
    logic [`JALR_PORTS-1:0][31:0] jalr_pc;
    control_word_t out_cw;
    rvfi_word_t    out_rvfi;

    logic [31:0] lfsr = 32'h7b21_14ff;
    int errors = 0;
    int checks = 0;
    int deq_count = 0;
    logic hold_deq = 1'b0;
    logic jalr_seen = 1'b0;
    logic flush_seen = 1'b0;
    logic [31:0] expect_pc = `RESET_PC;
    logic pred_taken [logic [31:0]];  // prediction bit given while each word was decoded

    front_end_top front_end_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [31:0] enc_i(opcode_t op, logic [4:0] rd, logic [2:0] f3,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_br};
    endfunction

    // program at the reset pc, address-derived addi everywhere else
    function automatic logic [31:0] mem_word(logic [31:0] a);
        logic [11:0] fill_imm;
        fill_imm = a[13:2] ^ a[25:14] ^ {a[31:26], 4'b0, a[1:0]};
        case (a)
            32'h60: return enc_i(op_imm, 5'd1, 3'd0, 5'd0, 12'd5);
            32'h64: return enc_i(op_imm, 5'd2, 3'd0, 5'd1, 12'hffd);
            32'h68: return enc_i(op_load, 5'd3, lw, 5'd1, 12'd8);
            32'h6c: return {7'h7f, 5'd3, 5'd2, sw, 5'h1c, op_store}; // sw x3,-4(x2)
            32'h70: return {20'h12345, 5'd4, op_lui};
            32'h74: return {20'h00001, 5'd5, op_auipc};
            32'h78: return {1'b0, 10'd8, 1'b0, 8'd0, 5'd1, op_jal};  // jal x1,+16
            32'h88: return enc_b(3'd0, 5'd1, 5'd2, 13'd8);
            32'h90: return enc_b(3'd4, 5'd1, 5'd2, 13'd8);
            32'h98: return enc_i(op_jalr, 5'd0, 3'd0, 5'd1, 12'd0);
            default: return enc_i(op_imm, a[6:2], 3'd0, a[11:7], fill_imm);
        endcase
    endfunction

    function automatic logic fetch_stalled();
        return front_end_top_i.dq_if.ld_iq && !front_end_top_i.dq_if.iq_ack;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout: %s", what);
    endtask

    // reference decode straight from the encoding rules
    task automatic check_entry(input control_word_t cw, input rvfi_word_t rv);
        instr_u w;
        logic [31:0] pc, i_imm, s_imm, b_imm, u_imm, j_imm, exp_data, exp_pc, exp_next;
        op_t exp_op;
        logic [4:0] exp_s1, exp_s2, exp_rd;
        logic exp_v2;
        logic taken;
        w = cw.og_instr;
        pc = cw.og_pc;
        i_imm = {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
        s_imm = {{20{w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
        b_imm = {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
        u_imm = {w.u.imm_31_12, 12'h0};
        j_imm = {{11{w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0};
        taken = pred_taken.exists(pc) && pred_taken[pc];
        exp_op = ARITH;
        exp_s1 = w.r.rs1;
        exp_s2 = w.r.rs2;
        exp_rd = w.r.rd;
        exp_v2 = 1'b0;
        exp_data = 32'h0;
        exp_pc = pc + 32'd4;
        exp_next = pc + 32'd4;
        case (w.r.opcode)
            op_lui, op_auipc, op_jal: begin
                exp_s1 = 5'd0;
                exp_s2 = 5'd0;
                exp_v2 = 1'b1;
                if (w.r.opcode == op_lui) begin
                    exp_op = LUI;
                    exp_pc = u_imm;
                end else if (w.r.opcode == op_auipc) begin
                    exp_op = AUIPC;
                    exp_pc = pc + u_imm;
                end else begin
                    exp_op = JAL;
                    exp_next = pc + j_imm;
                end
            end
            op_br: begin
                exp_op = BRANCH;
                if (taken) begin
                    exp_rd = 5'd2;
                    exp_next = pc + b_imm;
                end else begin
                    exp_rd = 5'd0;
                    exp_pc = pc + b_imm;
                end
            end
            op_store: begin
                exp_op = (w.s.funct3 == sb) ? SB : (w.s.funct3 == sh) ? SH : SW;
                exp_v2 = 1'b1;
                exp_data = s_imm;
            end
            op_load, op_imm, op_jalr, op_csr: begin
                exp_s2 = 5'd0;
                exp_v2 = 1'b1;
                exp_data = i_imm;
                if (w.r.opcode == op_jalr)
                    exp_op = JALR;
                else if (w.r.opcode == op_load)
                    exp_op = (w.i.funct3 == lb) ? LB : (w.i.funct3 == lh) ? LH :
                             (w.i.funct3 == lbu) ? LBU : (w.i.funct3 == lhu) ? LHU : LW;
            end
            default: ;
        endcase
        check_val("out_cw.og_instr", cw.og_instr, mem_word(pc));
        check_val("out_cw.op", 32'(cw.op), 32'(exp_op));
        check_val("out_cw.src1_reg", 32'(cw.src1_reg), 32'(exp_s1));
        check_val("out_cw.src2_reg", 32'(cw.src2_reg), 32'(exp_s2));
        check_val("out_cw.src2_valid", 32'(cw.src2_valid), 32'(exp_v2));
        check_val("out_cw.src2_data", cw.src2_data, exp_data);
        check_val("out_cw.funct3", 32'(cw.funct3), 32'(w.r.funct3));
        check_val("out_cw.funct7", 32'(cw.funct7), 32'(w.r.funct7[5]));
        check_val("out_cw.rd", 32'(cw.rd), 32'(exp_rd));
        check_val("out_cw.pc", cw.pc, exp_pc);
        check_val("out_rvfi.inst", rv.inst, mem_word(pc));
        check_val("out_rvfi.rs1_addr", 32'(rv.rs1_addr), 32'(w.r.rs1));
        check_val("out_rvfi.rs2_addr", 32'(rv.rs2_addr), 32'(w.r.rs2));
        check_val("out_rvfi.rd_addr", 32'(rv.rd_addr), 32'(w.r.rd));
        check_val("out_rvfi.pc_rdata", rv.pc_rdata, pc);
        check_val("out_rvfi.pc_wdata", rv.pc_wdata, exp_next);
    endtask

    // scoreboard, sampled on the edge that pops the head
    always @(posedge clk) begin
        if (!rst) begin
            if (flush_ip) begin
                expect_pc = FLUSH_PC;
                flush_seen = 1'b1;
            end else if (out_valid && deq) begin
                check_entry(out_cw, out_rvfi);
                check_val("out_cw.og_pc", out_cw.og_pc, expect_pc);
                expect_pc = (out_cw.op == JALR) ? JALR_TGT : out_rvfi.pc_wdata;
                if (out_cw.op == JALR)
                    jalr_seen = 1'b1;
                deq_count++;
            end
        end
    end

    // memory model and per-cycle random inputs
    initial begin : stimulus
        logic pend;
        logic hold_now;
        logic resp_last;
        logic [31:0] resp_addr;
        int cnt;
        pend = 1'b0;
        resp_addr = 32'h0;
        cnt = 0;
        instr_mem_resp = 1'b0;
        instr_rdata = 32'h0;
        br_pr_take = 1'b0;
        deq = 1'b0;
        forever begin
            @(posedge clk);
            hold_now = hold_deq;
            #2;
            resp_last = instr_mem_resp;
            instr_mem_resp = 1'b0;
            br_pr_take = lfsr_bit();
            if (resp_last)
                pred_taken[resp_addr] = br_pr_take; // word decoded in this cycle
            deq = !hold_now && (lfsr_bit() | lfsr_bit());
            if (rst) begin
                pend = 1'b0;
            end else if (instr_read) begin
                if (!pend) begin
                    pend = 1'b1;
                    cnt = {lfsr_bit(), lfsr_bit()};  // 1 to 4 cycles
                end
                if (cnt == 0) begin
                    instr_mem_resp = 1'b1;
                    resp_addr = instr_mem_address;
                    instr_rdata = mem_word(instr_mem_address);
                    pend = 1'b0;
                end else begin
                    cnt--;
                end
            end
        end
    end

    task automatic resolve_jalr(output logic ok);
        int i;
        ok = 1'b1;
        for (i = 0; i < 800 && !jalr_seen; i++)
            @(posedge clk);
        if (!jalr_seen) begin
            report_timeout("no JALR reached the dispatch side");
            ok = 1'b0;
        end else begin
            repeat (3) @(posedge clk);
            #2;
            jalr_done = 4'b1010;     // port 3 must win over port 1
            jalr_pc[1] = 32'h300;
            jalr_pc[3] = JALR_TGT;
            @(posedge clk);
            #2 jalr_done = '0;
        end
    endtask

    // hold the dispatch side until fetch stalls on a full queue
    task automatic fill_and_drain(output logic ok);
        int i;
        int base;
        ok = 1'b1;
        hold_deq = 1'b1;
        for (i = 0; i < 400 && !fetch_stalled(); i++)
            @(posedge clk);
        if (!fetch_stalled()) begin
            report_timeout("queue never filled while dequeue was held");
            ok = 1'b0;
        end else begin
            repeat (20) @(posedge clk);
            #2 hold_deq = 1'b0;
            base = deq_count;
            for (i = 0; i < 600 && deq_count < base + 12; i++)
                @(posedge clk);
            if (deq_count < base + 12) begin
                report_timeout("queue did not drain after back-pressure");
                ok = 1'b0;
            end
        end
    endtask

    // flush with entries still waiting in the queue
    task automatic flush_and_refill(output logic ok);
        int i;
        int base;
        ok = 1'b1;
        @(posedge clk);
        #2 hold_deq = 1'b1;
        repeat (2) @(posedge clk);
        for (i = 0; i < 200 && !out_valid; i++)
            @(posedge clk);
        if (!out_valid) begin
            report_timeout("queue stayed empty before the flush");
            ok = 1'b0;
        end else begin
            #2;
            ld_br_pc = 1'b1;
            br_pc = FLUSH_PC;
            @(posedge clk);
            #2;
            ld_br_pc = 1'b0;
            flush_ip = 1'b1;
            @(posedge clk);
            #2;
            flush_ip = 1'b0;
            hold_deq = 1'b0;
            base = deq_count;
            for (i = 0; i < 600 && deq_count < base + 10; i++)
                @(posedge clk);
            if (deq_count < base + 10 || !flush_seen) begin
                report_timeout("no entries dequeued after the flush");
                ok = 1'b0;
            end
        end
    endtask

    initial begin : sequence_main
        logic ok;
        rst = 1'b1;
        ld_br_pc = 1'b0;
        br_pc = 32'h0;
        flush_ip = 1'b0;
        jalr_done = '0;
        jalr_pc = '0;
        repeat (16) @(posedge clk);
        #2 rst = 1'b0;

        resolve_jalr(ok);
        if (ok)
            fill_and_drain(ok);
        if (ok)
            flush_and_refill(ok);

        $display("errors: %0d checks: %0d dequeued: %0d", errors, checks, deq_count);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- sim/front_end_sva.sv
`timescale 1ns/1ns
`include "front_consts.svh"

module front_end_sva (
    input logic                         clk,
    input logic                         rst,
    input logic                         instr_read,
    input logic [31:0]                  instr_mem_address,
    input logic                         instr_mem_resp,
    input logic                         flush_ip,
    input logic [`JALR_PORTS-1:0]       jalr_done,
    input logic [`JALR_PORTS-1:0][31:0] jalr_pc,
    input logic                         out_valid,
    input logic                         ld_iq,
    input logic                         iq_ack,
    input tomasulo_pkg::op_t            ld_op
);
    import tomasulo_pkg::*;

    logic        read_seen;
    logic        jalr_pending;  // jalr accepted, target not back yet
    logic [31:0] jalr_win;

    always_comb begin
        jalr_win = 32'h0;
        for (int p = 0; p < `JALR_PORTS; p++) begin
            if (jalr_done[p])
                jalr_win = jalr_pc[p];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_seen    <= 1'b0;
            jalr_pending <= 1'b0;
        end else begin
            if (instr_read)
                read_seen <= 1'b1;
            if (ld_iq && iq_ack && ld_op == JALR)
                jalr_pending <= 1'b1;
            else if (|jalr_done || flush_ip)
                jalr_pending <= 1'b0;
        end
    end

    assert property (@(posedge clk) rst |-> !out_valid && !instr_read)
        else $error("output active during reset");
    assert property (@(posedge clk) $fell(rst) |-> !out_valid && !instr_read)
        else $error("output active in the first cycle after reset");
    assert property (@(posedge clk) disable iff (rst)
        instr_read && !read_seen |-> instr_mem_address == `RESET_PC)
        else $error("first fetch not at the reset pc");
    assert property (@(posedge clk) disable iff (rst)
        instr_read && !instr_mem_resp |=> instr_read && $stable(instr_mem_address))
        else $error("fetch request dropped or moved before its response");
    assert property (@(posedge clk) disable iff (rst) jalr_pending |-> !instr_read)
        else $error("fetch issued while a jalr target is unknown");
    assert property (@(posedge clk) disable iff (rst)
        jalr_pending && |jalr_done && !flush_ip
        |=> instr_read && instr_mem_address == $past(jalr_win))
        else $error("fetch after jalr not at the resolved target");
    assert property (@(posedge clk) disable iff (rst) flush_ip |=> !out_valid)
        else $error("queue not empty after flush");
    assert property (@(posedge clk) disable iff (rst) flush_ip |-> !ld_iq)
        else $error("queue load during flush");

endmodule

bind front_end_top front_end_sva front_end_sva_i (
    .clk               (clk),
    .rst               (rst),
    .instr_read        (instr_read),
    .instr_mem_address (instr_mem_address),
    .instr_mem_resp    (instr_mem_resp),
    .flush_ip          (flush_ip),
    .jalr_done         (jalr_done),
    .jalr_pc           (jalr_pc),
    .out_valid         (out_valid),
    .ld_iq             (dq_if.ld_iq),
    .iq_ack            (dq_if.iq_ack),
    .ld_op             (dq_if.control_word.op)
);

//--- verilog/front_end_top.sv
`timescale 1ns/1ns
`include "front_consts.svh"

module front_end_top (
    input  logic                         clk,
    input  logic                         rst,
    output logic                         instr_read,
    output logic [31:0]                  instr_mem_address,
    input  logic                         instr_mem_resp,
    input  logic [31:0]                  instr_rdata,
    input  logic                         br_pr_take,
    input  logic                         ld_br_pc,
    input  logic [31:0]                  br_pc,
    input  logic                         flush_ip,
    input  logic [`JALR_PORTS-1:0]       jalr_done,
    input  logic [`JALR_PORTS-1:0][31:0] jalr_pc,
    input  logic                         deq,
    output logic                         out_valid,
    output tomasulo_pkg::control_word_t  out_cw,
    output tomasulo_pkg::rvfi_word_t     out_rvfi
);

    dispatch_if dq_if ();

    // fetch, predict and decode
    fetch_decode fetch_decode_i (
        .clk               (clk),
        .rst               (rst),
        .instr_mem_resp    (instr_mem_resp),
        .instr_rdata       (instr_rdata),
        .br_pr_take        (br_pr_take),
        .flush_ip          (flush_ip),
        .ld_br_pc          (ld_br_pc),
        .br_pc             (br_pc),
        .jalr_done         (jalr_done),
        .jalr_pc           (jalr_pc),
        .instr_read        (instr_read),
        .instr_mem_address (instr_mem_address),
        .dq                (dq_if.fetch)
    );

    instr_queue #(
        .DEPTH (`IQ_DEPTH)
    ) instr_queue_i (
        .clk       (clk),
        .rst       (rst),
        .flush_ip  (flush_ip),
        .deq       (deq),
        .dq        (dq_if.queue),
        .out_valid (out_valid),
        .out_cw    (out_cw),
        .out_rvfi  (out_rvfi)
    );

endmodule

//--- front/instr_queue.sv
`timescale 1ns/1ns
`include "front_consts.svh"

module instr_queue #(
    parameter int DEPTH = `IQ_DEPTH
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_ip,
    input  logic                        deq,
    dispatch_if.queue                   dq,
    output logic                        out_valid,
    output tomasulo_pkg::control_word_t out_cw,
    output tomasulo_pkg::rvfi_word_t    out_rvfi
);
    import tomasulo_pkg::*;

    localparam int PTR_W   = $clog2(DEPTH);
    localparam int ENTRY_W = $bits(control_word_t) + $bits(rvfi_word_t);

    logic [ENTRY_W-1:0] mem [DEPTH];  // control word above debug word
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic [PTR_W:0]     count;
    logic               full;
    logic               push;
    logic               pop;

    assign full      = (count == (PTR_W+1)'(DEPTH));
    assign dq.iq_ack = dq.ld_iq & ~full;   // same-cycle accept
    assign push      = dq.iq_ack;
    assign out_valid = (count != '0);
    assign pop       = deq & out_valid;

    assign {out_cw, out_rvfi} = mem[head];

    always_ff @(posedge clk) begin
        if (push)
            mem[tail] <= {dq.control_word, dq.rvfi};
    end

    // flush drops every entry at once
    always_ff @(posedge clk) begin
        if (rst || flush_ip) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push)
                tail <= tail + 1'b1;
            if (pop)
                head <= head + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- front/fetch_decode.sv
`timescale 1ns/1ns
`include "front_consts.svh"

module fetch_decode (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instr_mem_resp,
    input  logic [31:0]                  instr_rdata,
    input  logic                         br_pr_take,
    input  logic                         flush_ip,
    input  logic                         ld_br_pc,
    input  logic [31:0]                  br_pc,
    input  logic [`JALR_PORTS-1:0]       jalr_done,
    input  logic [`JALR_PORTS-1:0][31:0] jalr_pc,
    output logic                         instr_read,
    output logic [31:0]                  instr_mem_address,
    dispatch_if.fetch                    dq
);
    import rv32i_pkg::*;
    import tomasulo_pkg::*;

    enum logic [2:0] {
        RESET,
        FETCH,
        CREATE,
        STALL,
        JALR_WAIT,
        JALR_FETCH,
        FLUSH_WAIT,
        FLUSH_FETCH
    } state, next_state;

    logic [31:0] pc;
    logic [31:0] prev_pc;       // pc of the word held in STALL
    logic [31:0] br_pc_buf;
    logic [31:0] jalr_pc_buf;
    logic [31:0] pred_tgt_buf;  // taken target of a stalled branch
    logic        take_buf;
    instr_u      ir;

    logic        ld_pc;
    logic [31:0] pc_load;
    logic [31:0] jalr_sel;
    logic        jalr_any;

    opcode_t     opc;
    logic [31:0] instr_pc;
    logic [31:0] seq_pc;
    logic [31:0] br_tgt;
    logic [31:0] next_pc;
    logic        take;
    logic [31:0] i_imm, s_imm, b_imm, u_imm, j_imm;

    control_word_t cw;
    rvfi_word_t    rv;

    assign dq.control_word = cw;
    assign dq.rvfi         = rv;

    // immediates straight from the format views
    assign opc   = ir.r.opcode;
    assign i_imm = {{20{ir.i.imm_11_0[11]}}, ir.i.imm_11_0};
    assign s_imm = {{20{ir.s.imm_11_5[6]}}, ir.s.imm_11_5, ir.s.imm_4_0};
    assign b_imm = {{19{ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11, ir.b.imm_10_5,
                    ir.b.imm_4_1, 1'b0};
    assign u_imm = {ir.u.imm_31_12, 12'h000};
    assign j_imm = {{11{ir.j.imm_20}}, ir.j.imm_20, ir.j.imm_19_12, ir.j.imm_11,
                    ir.j.imm_10_1, 1'b0};

    // pc already moved on once CREATE has offered the word
    assign instr_pc = (state == STALL) ? prev_pc : pc;
    assign take     = (state == STALL) ? take_buf : br_pr_take;
    assign br_tgt   = (state == STALL) ? pred_tgt_buf : pc + b_imm;
    assign seq_pc   = instr_pc + 32'd4;

    // highest numbered port wins
    always_comb begin
        jalr_sel = jalr_pc_buf;
        for (int p = 0; p < `JALR_PORTS; p++) begin
            if (jalr_done[p])
                jalr_sel = jalr_pc[p];
        end
    end

    assign jalr_any = |jalr_done;

    always_comb begin : decode
        next_pc       = seq_pc;
        cw.op         = ARITH;
        cw.src1_reg   = ir.r.rs1;
        cw.src1_valid = 1'b0;
        cw.src2_reg   = ir.r.rs2;
        cw.src2_valid = 1'b0;
        cw.src2_data  = 32'h0;
        cw.funct3     = ir.r.funct3;
        cw.funct7     = ir.r.funct7[5];
        cw.rd         = ir.r.rd;
        cw.pc         = seq_pc;
        cw.og_pc      = instr_pc;
        cw.og_instr   = ir;

        case (opc)
            op_lui, op_auipc, op_jal: begin
                cw.src1_reg   = 5'd0;
                cw.src2_reg   = 5'd0;
                cw.src2_valid = 1'b1;
                if (opc == op_lui) begin
                    cw.op = LUI;
                    cw.pc = u_imm;
                end else if (opc == op_auipc) begin
                    cw.op = AUIPC;
                    cw.pc = instr_pc + u_imm;
                end else begin
                    cw.op   = JAL;
                    next_pc = instr_pc + j_imm; // link value stays in cw.pc
                end
            end
            op_br: begin
                cw.op = BRANCH;
                if (take) begin
                    next_pc = br_tgt;
                    cw.rd   = 5'd2;    // marks taken prediction
                end else begin
                    cw.pc = br_tgt;    // fallback if resolved taken
                    cw.rd = 5'd0;
                end
            end
            op_store: begin
                case (ir.s.funct3)
                    sb:      cw.op = SB;
                    sh:      cw.op = SH;
                    default: cw.op = SW;
                endcase
                cw.src2_valid = 1'b1;
                cw.src2_data  = s_imm; // rs2 still names the store data
            end
            op_load, op_imm, op_jalr, op_csr: begin
                cw.src2_reg   = 5'd0;
                cw.src2_valid = 1'b1;
                cw.src2_data  = i_imm;
                if (opc == op_jalr)
                    cw.op = JALR;
                if (opc == op_load) begin
                    case (ir.i.funct3)
                        lb:      cw.op = LB;
                        lh:      cw.op = LH;
                        lbu:     cw.op = LBU;
                        lhu:     cw.op = LHU;
                        default: cw.op = LW;
                    endcase
                end
            end
            op_reg: ;                  // defaults already fit
            default: ;
        endcase

        rv.inst     = ir;
        rv.rs1_addr = ir.r.rs1;
        rv.rs2_addr = ir.r.rs2;
        rv.rd_addr  = ir.r.rd;
        rv.pc_rdata = instr_pc;
        rv.pc_wdata = next_pc;
        rv.imm      = cw.src2_valid & (opc != op_store);
    end

    always_comb begin : fsm
        next_state        = state;
        instr_read        = 1'b0;
        instr_mem_address = pc;
        dq.ld_iq          = 1'b0;
        ld_pc             = 1'b0;
        pc_load           = next_pc;

        case (state)
            RESET: next_state = FETCH;
            FETCH: begin
                instr_read = 1'b1;
                if (instr_mem_resp)
                    next_state = flush_ip ? FLUSH_FETCH : CREATE;
                else if (flush_ip)
                    next_state = FLUSH_WAIT;
            end
            CREATE, STALL: begin
                dq.ld_iq = ~flush_ip;
                if (flush_ip) begin
                    next_state = FLUSH_FETCH;
                end else begin
                    ld_pc = (state == CREATE);
                    if (!dq.iq_ack)
                        next_state = STALL;
                    else if (opc == op_jalr)
                        next_state = JALR_WAIT; // target unknown until executed
                    else
                        next_state = FETCH;
                end
            end
            JALR_WAIT: begin
                if (flush_ip)
                    next_state = FLUSH_FETCH;
                else if (jalr_any)
                    next_state = JALR_FETCH;
            end
            JALR_FETCH: begin
                instr_read        = 1'b1;
                instr_mem_address = jalr_pc_buf;
                ld_pc             = 1'b1;
                pc_load           = jalr_pc_buf;
                if (instr_mem_resp)
                    next_state = flush_ip ? FLUSH_FETCH : CREATE;
                else if (flush_ip)
                    next_state = FLUSH_WAIT;
            end
            // let the read in flight finish, its data is thrown away
            FLUSH_WAIT: begin
                instr_read = 1'b1;
                if (instr_mem_resp)
                    next_state = FLUSH_FETCH;
            end
            FLUSH_FETCH: begin
                ld_pc   = 1'b1;
                pc_load = br_pc_buf;
                if (!flush_ip)
                    next_state = FETCH;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RESET;
            pc    <= `RESET_PC;
        end else begin
            state <= next_state;
            if (ld_pc)
                pc <= pc_load;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_read && instr_mem_resp)
            ir <= instr_rdata;
        if (ld_br_pc)
            br_pc_buf <= br_pc;
        if (state == JALR_WAIT && jalr_any)
            jalr_pc_buf <= jalr_sel;
        if (state == CREATE) begin
            prev_pc      <= pc;
            take_buf     <= br_pr_take;
            pred_tgt_buf <= br_tgt;
        end
    end

endmodule

//--- common/dispatch_if.sv
`timescale 1ns/1ns

interface dispatch_if;
    import tomasulo_pkg::*;

    logic          ld_iq;         // decoded word offered
    logic          iq_ack;        // taken in the same cycle
    control_word_t control_word;
    rvfi_word_t    rvfi;

    modport fetch (
        output ld_iq,
        output control_word,
        output rvfi,
        input  iq_ack
    );

    modport queue (
        input  ld_iq,
        input  control_word,
        input  rvfi,
        output iq_ack
    );

endinterface

//--- common/tomasulo_pkg.sv
package tomasulo_pkg;

    // operation classes seen by the reservation stations
    typedef enum logic [3:0] {
        ARITH,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BRANCH,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [4:0]  src1_reg;
        logic        src1_valid;
        logic [4:0]  src2_reg;
        logic        src2_valid;
        logic [31:0] src2_data;  // immediate operand
        logic [2:0]  funct3;
        logic        funct7;     // bit 30 only
        logic [4:0]  rd;
        logic [31:0] pc;         // result or alternate target
        logic [31:0] og_pc;
        logic [31:0] og_instr;
    } control_word_t;

    // debug trace word travelling next to each control word
    typedef struct packed {
        logic [31:0] inst;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [4:0]  rd_addr;
        logic [31:0] pc_rdata;
        logic [31:0] pc_wdata;   // predicted next pc
        logic        imm;
    } rvfi_word_t;

endpackage

//--- common/rv32i_pkg.sv
package rv32i_pkg;

    // major opcodes, low seven bits of every word
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011, // all conditional branches
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // one struct per encoding format, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

//--- common/front_consts.svh
`ifndef FRONT_CONSTS_SVH
`define FRONT_CONSTS_SVH

// first fetch address after reset
`define RESET_PC 32'h60

// decoded entries held between fetch and dispatch
`define IQ_DEPTH 8

`define JALR_PORTS 4 // execution ports able to resolve a jalr

`endif
